// ==== board_pkg.sv ====
`default_nettype none

package board_pkg;

    // Address map, byte addresses on the data bus
    localparam logic [63:0] rom_base = 64'd0;
    localparam logic [63:0] rom_size = 64'd4096;
    localparam logic [63:0] ram_base = 64'd4096;
    localparam logic [63:0] ram_size = 64'd8192;

    // Single-word peripheral registers
    localparam logic [63:0] art_addr = 64'd12288;
    localparam logic [63:0] key_addr = 64'd12296;

    // Unified instruction/data memory
    localparam int mem_words  = 3072;
    localparam int mem_addr_w = 12;

    // PS/2 set-2 framing and codes
    localparam int          ps2_frame_bits = 11;
    localparam logic [7:0]  ps2_break_code = 8'hF0;

    // Interrupt vector raised by a key press
    localparam logic [3:0]  kbd_irq_vector = 4'd1;

    // Data-bus request as issued by the CPU
    typedef struct packed {
        logic [63:0] addr;
        logic [63:0] wdata;
        logic        we;
        logic        re;
    } bus_req_t;

    // Decoded key event from the PS/2 receiver
    typedef struct packed {
        logic       valid;
        logic       pressed;
        logic       released;
        logic [7:0] scan;
        logic [7:0] ascii;
    } key_event_t;

    // Memory data port request, already gated by the hub
    typedef struct packed {
        logic [mem_addr_w-1:0] addr;
        logic [31:0]           wdata;
        logic                  we;
    } mem_port_t;

endpackage

`default_nettype wire

// ==== scan_ascii_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_ascii_map (
    input  logic [7:0] scan,
    output logic [7:0] ascii
);

    // Set-2 make codes, letters map to upper case
    always_comb begin
        case (scan)
            8'h1C: ascii = "A";
            8'h32: ascii = "B";
            8'h21: ascii = "C";
            8'h23: ascii = "D";
            8'h24: ascii = "E";
            8'h2B: ascii = "F";
            8'h34: ascii = "G";
            8'h33: ascii = "H";
            8'h43: ascii = "I";
            8'h3B: ascii = "J";
            8'h42: ascii = "K";
            8'h4B: ascii = "L";
            8'h3A: ascii = "M";
            8'h31: ascii = "N";
            8'h44: ascii = "O";
            8'h4D: ascii = "P";
            8'h15: ascii = "Q";
            8'h2D: ascii = "R";
            8'h1B: ascii = "S";
            8'h2C: ascii = "T";
            8'h3C: ascii = "U";
            8'h2A: ascii = "V";
            8'h1D: ascii = "W";
            8'h22: ascii = "X";
            8'h35: ascii = "Y";
            8'h1A: ascii = "Z";
            // Top row digits
            8'h45: ascii = "0";
            8'h16: ascii = "1";
            8'h1E: ascii = "2";
            8'h26: ascii = "3";
            8'h25: ascii = "4";
            8'h2E: ascii = "5";
            8'h36: ascii = "6";
            8'h3D: ascii = "7";
            8'h3E: ascii = "8";
            8'h46: ascii = "9";
            8'h29: ascii = 8'h20;
            // Enter gives carriage return
            8'h5A: ascii = 8'h0D;
            default: ascii = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

// ==== ps2_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_receiver (
    input  logic                  clock_50,
    input  logic                  key0,
    input  logic                  ps2_clk,
    input  logic                  ps2_dat,
    output board_pkg::key_event_t key_event
);

    logic [1:0]  clk_sync;
    logic [1:0]  dat_sync;
    logic        clk_prev;
    logic        clk_fall;
    logic [3:0]  bit_cnt;
    logic [board_pkg::ps2_frame_bits-1:0] frame;
    logic        frame_done;
    logic        break_armed;
    logic [7:0]  frame_byte;
    logic        frame_ok;
    logic [7:0]  frame_ascii;
    board_pkg::key_event_t event_q;

    // Two-flop synchronizers on the keyboard lines
    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // Device drives data while its clock is high, sample on the fall
    assign clk_fall = clk_prev && !clk_sync[1];

    // Stage one: shift in start, data LSB first, parity and stop
    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            bit_cnt    <= '0;
            frame      <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (clk_fall) begin
                frame <= {dat_sync[1], frame[board_pkg::ps2_frame_bits-1:1]};
                if (bit_cnt == 4'(board_pkg::ps2_frame_bits - 1)) begin
                    bit_cnt    <= '0;
                    frame_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // Frame layout after eleven shifts
    assign frame_byte = frame[8:1];
    assign frame_ok   = !frame[0] && frame[10] && (^frame[9:1]);

    scan_ascii_map map_i (
        .scan  (frame_byte),
        .ascii (frame_ascii)
    );

    // Stage two: check the frame and build the event
    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            event_q     <= '0;
            break_armed <= 1'b0;
        end else begin
            event_q.valid <= 1'b0;
            if (frame_done && frame_ok) begin
                if (frame_byte == board_pkg::ps2_break_code) begin
                    // Next code is the key being let go
                    break_armed <= 1'b1;
                end else begin
                    event_q.valid    <= 1'b1;
                    event_q.pressed  <= !break_armed;
                    event_q.released <= break_armed;
                    event_q.scan     <= frame_byte;
                    event_q.ascii    <= frame_ascii;
                    break_armed      <= 1'b0;
                end
            end
        end
    end

    assign key_event = event_q;

endmodule

`default_nettype wire

// ==== board_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_memory (
    input  logic                 clock_50,
    input  logic [63:0]          pc,
    output logic [31:0]          instr,
    input  board_pkg::mem_port_t port,
    output logic [31:0]          rdata
);

    logic [31:0] mem [board_pkg::mem_words];
    logic [31:0] fetch_q;
    logic [31:0] data_q;
    logic [board_pkg::mem_addr_w-1:0] fetch_idx;

    // Block RAM power-up contents
    initial begin
        for (int i = 0; i < board_pkg::mem_words; i++) begin
            mem[i] = '0;
        end
    end

    // Word index of the fetch address
    assign fetch_idx = pc[board_pkg::mem_addr_w+1:2];

    // Instruction fetch port
    always_ff @(posedge clock_50) begin
        fetch_q <= mem[fetch_idx];
    end

    // Data port, a read in the write cycle sees the old word
    always_ff @(posedge clock_50) begin
        data_q <= mem[port.addr];
        if (port.we) begin
            mem[port.addr] <= port.wdata;
        end
    end

    // Stored words are big-endian relative to the core
    assign instr = {fetch_q[7:0], fetch_q[15:8], fetch_q[23:16], fetch_q[31:24]};

    assign rdata = data_q;

endmodule

`default_nettype wire

// ==== peripheral_hub.sv ====
`timescale 1ns/1ps
`default_nettype none

module peripheral_hub (
    input  logic                  clock_50,
    input  logic                  key0,
    input  board_pkg::bus_req_t   req,
    output board_pkg::mem_port_t  mem_port,
    input  logic [31:0]           mem_rdata,
    input  board_pkg::key_event_t key_event,
    input  logic                  irq_ack,
    output logic [63:0]           rdata,
    output logic                  uart_write,
    output logic [7:0]            uart_data,
    output logic [3:0]            irq_vector,
    output logic                  kbd_irq
);

    // Read source held for the cycle the memory word appears
    typedef struct packed {
        logic mem;
        logic key;
    } read_sel_t;

    logic      rom_sel;
    logic      ram_sel;
    logic      art_sel;
    logic      key_sel;
    read_sel_t sel_q;
    logic      art_we;
    logic      art_we_q;
    logic [7:0] kbd_data;
    logic      key_press;
    logic [3:0] vector_q;

    // Region decode
    assign rom_sel = (req.addr >= board_pkg::rom_base) &&
                     (req.addr < board_pkg::rom_base + board_pkg::rom_size);
    assign ram_sel = (req.addr >= board_pkg::ram_base) &&
                     (req.addr < board_pkg::ram_base + board_pkg::ram_size);
    assign art_sel = (req.addr == board_pkg::art_addr);
    assign key_sel = (req.addr == board_pkg::key_addr);

    // Only RAM accepts stores
    assign mem_port.addr  = req.addr[board_pkg::mem_addr_w+1:2];
    assign mem_port.wdata = req.wdata[31:0];
    assign mem_port.we    = req.we && ram_sel;

    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            sel_q <= '0;
        end else begin
            sel_q.mem <= req.re && (rom_sel || ram_sel);
            sel_q.key <= req.re && key_sel;
        end
    end

    // Unmapped space reads as zero
    always_comb begin
        if (sel_q.mem) begin
            rdata = {32'd0, mem_rdata};
        end else if (sel_q.key) begin
            rdata = {56'd0, kbd_data};
        end else begin
            rdata = '0;
        end
    end

    // Console strobe on the first cycle of a write
    assign art_we = req.we && art_sel;

    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            art_we_q <= 1'b0;
        end else begin
            art_we_q <= art_we;
        end
    end

    assign uart_write = art_we && !art_we_q;
    assign uart_data  = req.wdata[7:0];

    assign key_press = key_event.valid && key_event.pressed;

    // Keyboard data register
    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            kbd_data <= '0;
        end else if (key_press) begin
            kbd_data <= key_event.ascii;
        end
    end

    // An ack wins over a press in the same cycle
    always_ff @(posedge clock_50 or negedge key0) begin
        if (!key0) begin
            vector_q <= '0;
        end else if (irq_ack) begin
            vector_q <= '0;
        end else if (key_press && (key_event.ascii != 8'd0)) begin
            vector_q <= board_pkg::kbd_irq_vector;
        end
    end

    assign irq_vector = vector_q;
    assign kbd_irq    = (vector_q != 4'd0);

endmodule

`default_nettype wire

// ==== cpu_board.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_board (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  logic [63:0]         pc,
    output logic [31:0]         instr,
    input  board_pkg::bus_req_t req,
    output logic [63:0]         rdata,
    input  logic                ps2_clk,
    input  logic                ps2_dat,
    input  logic                irq_ack,
    output logic                uart_write,
    output logic [7:0]          uart_data,
    output logic [3:0]          irq_vector,
    output logic                kbd_irq
);

    board_pkg::mem_port_t  mem_port;
    logic [31:0]           mem_rdata;
    board_pkg::key_event_t key_event;

    // Shared instruction and data store
    board_memory memory_i (
        .clock_50 (CLOCK_50),
        .pc       (pc),
        .instr    (instr),
        .port     (mem_port),
        .rdata    (mem_rdata)
    );

    // Keyboard front end
    ps2_receiver ps2_i (
        .clock_50  (CLOCK_50),
        .key0      (KEY0),
        .ps2_clk   (ps2_clk),
        .ps2_dat   (ps2_dat),
        .key_event (key_event)
    );

    // Bus decode, console and interrupt
    peripheral_hub hub_i (
        .clock_50   (CLOCK_50),
        .key0       (KEY0),
        .req        (req),
        .mem_port   (mem_port),
        .mem_rdata  (mem_rdata),
        .key_event  (key_event),
        .irq_ack    (irq_ack),
        .rdata      (rdata),
        .uart_write (uart_write),
        .uart_data  (uart_data),
        .irq_vector (irq_vector),
        .kbd_irq    (kbd_irq)
    );

endmodule

`default_nettype wire

// ==== tb_cpu_board.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_board;

    localparam int clk_period    = 100;
    localparam int reset_cycles  = 16;
    // Half of the 20 us PS/2 bit period in system clocks
    localparam int half_bit      = 100;
    localparam int n_steps       = 24;
    localparam int max_op_cycles = 11 * 2 * half_bit + 100;
    localparam int timeout_ns    = (reset_cycles + n_steps * max_op_cycles + 200) * clk_period;

    typedef enum logic [2:0] {op_write, op_read, op_fetch, op_key, op_ack, op_idle} op_kind_t;

    // arg is hold cycles, scan code or idle cycles; flag is same-cycle read or bad parity
    typedef struct packed {
        op_kind_t    kind;
        logic [63:0] addr;
        logic [7:0]  arg;
        logic        flag;
        logic [7:0]  exp;
    } step_t;

    logic                clock;
    logic                key0;
    logic [63:0]         pc;
    logic [31:0]         instr;
    board_pkg::bus_req_t req;
    logic [63:0]         rdata;
    logic                ps2_clk;
    logic                ps2_dat;
    logic                irq_ack;
    logic                uart_write;
    logic [7:0]          uart_data;
    logic [3:0]          irq_vector;
    logic                kbd_irq;

    step_t       steps [n_steps];
    logic [31:0] shadow [board_pkg::mem_words];
    logic [7:0]  kbd_model;
    logic [3:0]  vec_model;
    logic        break_model;
    logic [15:0] lfsr_state;
    logic [7:0]  uart_seen;
    int          error_count;
    int          check_count;
    int          event_count;
    int          uart_count;
    int          errors_before;

    cpu_board dut_i (
        .CLOCK_50   (clock),
        .KEY0       (key0),
        .pc         (pc),
        .instr      (instr),
        .req        (req),
        .rdata      (rdata),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .irq_ack    (irq_ack),
        .uart_write (uart_write),
        .uart_data  (uart_data),
        .irq_vector (irq_vector),
        .kbd_irq    (kbd_irq)
    );

    always #(clk_period / 2) clock = ~clock;

    // Console strobes and key events as seen at the clock edge
    always @(posedge clock) begin
        if (uart_write) begin
            uart_count = uart_count + 1;
            uart_seen  = uart_data;
        end
        if (dut_i.key_event.valid) begin
            event_count = event_count + 1;
        end
    end

    initial begin
        #(timeout_ns);
        $display("Timeout: the run did not finish within %0d ns", timeout_ns);
        $display("tests failed");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[62:0], lfsr_state[0]};
        end
    endtask

    function automatic step_t make_step(input op_kind_t kind, input logic [63:0] addr,
                                        input logic [7:0] arg, input logic flag,
                                        input logic [7:0] exp);
        return '{kind, addr, arg, flag, exp};
    endfunction

    function automatic logic in_mem_window(input logic [63:0] addr);
        return (addr >= board_pkg::rom_base &&
                addr < board_pkg::rom_base + board_pkg::rom_size) ||
               (addr >= board_pkg::ram_base &&
                addr < board_pkg::ram_base + board_pkg::ram_size);
    endfunction

    function automatic logic [63:0] expected_read(input logic [63:0] addr);
        if (in_mem_window(addr)) begin
            return {32'd0, shadow[addr[13:2]]};
        end else if (addr == board_pkg::key_addr) begin
            return {56'd0, kbd_model};
        end
        return '0;
    endfunction

    // Fetch sees the stored word with its bytes reversed
    function automatic logic [31:0] expected_fetch(input logic [63:0] addr);
        logic [31:0] w;
        w = shadow[addr[13:2]];
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    task automatic flag_error(input string what);
        check_count++;
        error_count++;
        $display("Error: %s", what);
    endtask

    task automatic check_rdata(input logic [63:0] got, input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch rdata: got %h, expected %h", got, exp);
        end
    endtask

    task automatic check_instr(input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch instr: got %h, expected %h", got, exp);
        end
    endtask

    task automatic check_key(input logic [7:0] got, input logic [7:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch keyboard data: got %h, expected %h", got, exp);
        end
    endtask

    task automatic check_irq(input logic [3:0] got, input logic [3:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch irq_vector: got %h, expected %h", got, exp);
        end
    endtask

    task automatic check_uart(input logic [7:0] got, input logic [7:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch uart_data: got %h, expected %h", got, exp);
        end
    endtask

    task automatic irq_outputs(input logic [3:0] exp);
        check_irq(irq_vector, exp);
        if (kbd_irq !== (exp != 4'd0)) begin
            flag_error("kbd_irq does not follow the interrupt vector");
        end
    endtask

    task automatic bus_read(input logic [63:0] addr, output logic [63:0] value);
        @(negedge clock);
        req = '{addr: addr, wdata: 64'd0, we: 1'b0, re: 1'b1};
        @(negedge clock);
        value  = rdata;
        req.re = 1'b0;
    endtask

    task automatic bus_write(input step_t s);
        logic [63:0] data;
        logic [63:0] old;
        draw_bits(64, data);
        old        = expected_read(s.addr);
        uart_count = 0;
        @(negedge clock);
        req = '{addr: s.addr, wdata: data, we: 1'b1, re: s.flag};
        repeat (s.arg - 1) @(negedge clock);
        @(negedge clock);
        // Read in the write cycle returns the previous word
        if (s.flag) begin
            check_rdata(rdata, old);
        end
        req = '0;
        if (s.addr >= board_pkg::ram_base &&
            s.addr < board_pkg::ram_base + board_pkg::ram_size) begin
            shadow[s.addr[13:2]] = data[31:0];
        end
        if (s.addr == board_pkg::art_addr) begin
            if (uart_count != 1) begin
                flag_error($sformatf("expected one console strobe, saw %0d", uart_count));
            end
            check_uart(uart_seen, data[7:0]);
        end
    endtask

    task automatic fetch_word(input logic [63:0] addr);
        @(negedge clock);
        pc = addr;
        @(negedge clock);
        check_instr(instr, expected_fetch(addr));
    endtask

    // Start, eight data bits LSB first, odd parity, stop
    task automatic send_ps2_frame(input logic [7:0] data, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_dat = bits[i];
            repeat (half_bit) @(negedge clock);
            ps2_clk = 1'b0;
            repeat (half_bit) @(negedge clock);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
    endtask

    task automatic key_frame(input step_t s);
        int          start;
        logic        expect_event;
        logic [63:0] value;
        start        = event_count;
        expect_event = !s.flag && (s.arg != board_pkg::ps2_break_code);
        send_ps2_frame(s.arg, s.flag);
        if (expect_event) begin
            wait (event_count != start);
        end
        repeat (4) @(negedge clock);
        if (event_count != start + (expect_event ? 1 : 0)) begin
            flag_error($sformatf("saw %0d key events for one frame", event_count - start));
        end
        // Break flag makes the following code a release
        if (!s.flag) begin
            if (s.arg == board_pkg::ps2_break_code) begin
                break_model = 1'b1;
            end else if (break_model) begin
                break_model = 1'b0;
            end else begin
                kbd_model = s.exp;
                if (s.exp != 8'd0) begin
                    vec_model = board_pkg::kbd_irq_vector;
                end
            end
        end
        bus_read(board_pkg::key_addr, value);
        check_key(value[7:0], kbd_model);
        irq_outputs(vec_model);
    endtask

    task automatic ack_irq();
        @(negedge clock);
        irq_ack = 1'b1;
        @(negedge clock);
        irq_ack   = 1'b0;
        vec_model = 4'd0;
        irq_outputs(vec_model);
    endtask

    initial begin
        logic [63:0] value;
        clock       = 1'b0;
        key0        = 1'b0;
        pc          = '0;
        req         = '0;
        ps2_clk     = 1'b1;
        ps2_dat     = 1'b1;
        irq_ack     = 1'b0;
        lfsr_state  = 16'd21;
        kbd_model   = '0;
        vec_model   = '0;
        break_model = 1'b0;
        uart_seen   = '0;
        error_count = 0;
        check_count = 0;
        event_count = 0;
        uart_count  = 0;
        for (int i = 0; i < board_pkg::mem_words; i++) begin
            shadow[i] = '0;
        end

        steps[0]  = make_step(op_write, 64'd4096, 8'd1, 1'b0, 8'h00);
        steps[1]  = make_step(op_write, 64'd4100, 8'd1, 1'b0, 8'h00);
        steps[2]  = make_step(op_write, 64'd12284, 8'd1, 1'b0, 8'h00);
        steps[3]  = make_step(op_read, 64'd4096, 8'd0, 1'b0, 8'h00);
        steps[4]  = make_step(op_read, 64'd4100, 8'd0, 1'b0, 8'h00);
        steps[5]  = make_step(op_read, 64'd12284, 8'd0, 1'b0, 8'h00);
        steps[6]  = make_step(op_write, 64'd4096, 8'd1, 1'b1, 8'h00);
        steps[7]  = make_step(op_read, 64'd4096, 8'd0, 1'b0, 8'h00);
        steps[8]  = make_step(op_write, 64'd16, 8'd1, 1'b0, 8'h00);
        steps[9]  = make_step(op_read, 64'd16, 8'd0, 1'b0, 8'h00);
        // Unmapped, but its low bits alias a written RAM word
        steps[10] = make_step(op_read, 64'd20480, 8'd0, 1'b0, 8'h00);
        steps[11] = make_step(op_fetch, 64'd4096, 8'd0, 1'b0, 8'h00);
        steps[12] = make_step(op_fetch, 64'd12284, 8'd0, 1'b0, 8'h00);
        steps[13] = make_step(op_fetch, 64'd16, 8'd0, 1'b0, 8'h00);
        steps[14] = make_step(op_write, board_pkg::art_addr, 8'd3, 1'b0, 8'h00);
        steps[15] = make_step(op_key, 64'd0, 8'h1C, 1'b0, 8'h41);
        steps[16] = make_step(op_ack, 64'd0, 8'd0, 1'b0, 8'h00);
        steps[17] = make_step(op_key, 64'd0, 8'h2B, 1'b0, 8'h46);
        steps[18] = make_step(op_ack, 64'd0, 8'd0, 1'b0, 8'h00);
        // Release of A while F is held and the vector is clear
        steps[19] = make_step(op_key, 64'd0, 8'hF0, 1'b0, 8'h00);
        steps[20] = make_step(op_key, 64'd0, 8'h1C, 1'b0, 8'h41);
        steps[21] = make_step(op_key, 64'd0, 8'h32, 1'b1, 8'h42);
        steps[22] = make_step(op_key, 64'd0, 8'h32, 1'b0, 8'h42);
        steps[23] = make_step(op_idle, 64'd0, 8'd4, 1'b0, 8'h00);

        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        key0 = 1'b1;
        irq_outputs(4'd0);
        if (uart_write !== 1'b0) begin
            flag_error("uart_write is active after reset");
        end

        for (int i = 0; i < n_steps; i++) begin
            errors_before = error_count;
            case (steps[i].kind)
                op_write: bus_write(steps[i]);
                op_read: begin
                    bus_read(steps[i].addr, value);
                    check_rdata(value, expected_read(steps[i].addr));
                end
                op_fetch: fetch_word(steps[i].addr);
                op_key:   key_frame(steps[i]);
                op_ack:   ack_irq();
                default:  repeat (steps[i].arg) @(negedge clock);
            endcase
            $display("step %0d %s %s", i, steps[i].kind.name(),
                     (error_count == errors_before) ? "ok" : "FAIL");
        end

        $display("summary: %0d steps, %0d checks, %0d errors",
                 n_steps, check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
board_pkg.sv
scan_ascii_map.sv
ps2_receiver.sv
board_memory.sv
peripheral_hub.sv
cpu_board.sv
tb_cpu_board.sv

// ==== Bender.yml ====
package:
  name: cpu_board

sources:
  - board_pkg.sv
  - scan_ascii_map.sv
  - ps2_receiver.sv
  - board_memory.sv
  - peripheral_hub.sv
  - cpu_board.sv
  - target: simulation
    files:
      - tb_cpu_board.sv
